//--- all.f
common/rast_pkg.sv
verilog/pipe_dly.sv
sample_test/sample_edge.sv
sample_test/sample_test.sv
verilog/rast_sample_top.sv
sim/sample_sb.sv
sim/sample_test_assert.sv
sim/tb_rast_sample.sv

//--- run.sh
#!/bin/sh
# Build and run the rasterizer sample test with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rast_sample \
    -Mdir obj_dir \
    -f all.f

./obj_dir/Vtb_rast_sample | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation finished cleanly"

//--- sim/tb_rast_sample.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rast_sample import rast_pkg::*; ();

    localparam int SIGFIG      = DEF_SIGFIG;
    localparam int NS          = DEF_NUM_SAMPLES;    // Table holds two samples
    localparam int NUM_ENTRIES = 8;
    localparam int NUM_RANDOM  = 200;
    localparam int DRAIN_MAX   = 50;                 // Cycles allowed to empty the pipe

    typedef struct packed {
        logic [127:0] name;
        int           v0x, v0y;
        int           v1x, v1y;
        int           v2x, v2y;
        int           s0x, s0y;
        int           s1x, s1y;
        logic [1:0]   valid;
        logic [1:0]   exp;                           // Expected hit mask
    } entry_t;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic signed [SIGFIG-1:0] v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;
    logic signed [SIGFIG-1:0] samp_x [NS];
    logic signed [SIGFIG-1:0] samp_y [NS];
    logic [NS-1:0]          samp_valid;
    logic [NS-1:0]          hit;
    logic [NS-1:0]          hit_valid;
    logic [NS-1:0]          exp_hit;
    int                     entry_idx;
    logic [127:0]           test_name;
    int                     err_valid, err_hit, err_table;
    logic                   busy;
    entry_t                 table_e [NUM_ENTRIES];

    always #10 clk = ~clk;                           // 20 ns period

    rast_sample_top i_rast_sample_top (
        .clk (clk), .arst_n (arst_n),
        .v0_x (v0_x), .v0_y (v0_y), .v1_x (v1_x), .v1_y (v1_y), .v2_x (v2_x), .v2_y (v2_y),
        .samp_x (samp_x), .samp_y (samp_y), .samp_valid (samp_valid),
        .hit (hit), .hit_valid (hit_valid)
    );

    sample_sb #(.SIGFIG (SIGFIG), .NUM_SAMPLES (NS)) i_sample_sb (
        .clk (clk), .arst_n (arst_n),
        .v0_x (v0_x), .v0_y (v0_y), .v1_x (v1_x), .v1_y (v1_y), .v2_x (v2_x), .v2_y (v2_y),
        .samp_x (samp_x), .samp_y (samp_y), .samp_valid (samp_valid),
        .hit (hit), .hit_valid (hit_valid), .exp_hit (exp_hit),
        .entry_idx (entry_idx), .test_name (test_name),
        .err_valid (err_valid), .err_hit (err_hit), .err_table (err_table), .busy (busy)
    );

    // Reference triangle (0,0) (100,0) (0,100) is CCW, interior where x+y < 100
    task automatic load_table();
        table_e[0] = '{"in_out", 0, 0, 100, 0, 0, 100, 20, 20, 200, 200, 2'b11, 2'b01};
        table_e[1] = '{"edge_vertex", 0, 0, 100, 0, 0, 100, 50, 0, 100, 0, 2'b11, 2'b00};
        table_e[2] = '{"clockwise", 0, 0, 0, 100, 100, 0, 20, 20, 10, 30, 2'b11, 2'b00};
        table_e[3] = '{"valid_off", 0, 0, 100, 0, 0, 100, 20, 20, 30, 30, 2'b10, 2'b10};
        table_e[4] = '{"hypotenuse", 0, 0, 100, 0, 0, 100, 50, 50, 49, 50, 2'b11, 2'b10};
        table_e[5] = '{"large_neg", -8000000, -8000000, -7000000, -8000000,
                       -8000000, -7000000, -7900000, -7900000, -8000001, -7500000,
                       2'b11, 2'b01};
        table_e[6] = '{"big_tri", -4000000, -4000000, 4000000, -4000000, 0, 4000000,
                       0, 0, 4000000, 4000000, 2'b11, 2'b01};
        table_e[7] = '{"both_off", 0, 0, 100, 0, 0, 100, 20, 20, 30, 30, 2'b00, 2'b00};
    endtask

    task automatic drive(input entry_t e, input int idx);
        v0_x       = SIGFIG'(e.v0x);
        v0_y       = SIGFIG'(e.v0y);
        v1_x       = SIGFIG'(e.v1x);
        v1_y       = SIGFIG'(e.v1y);
        v2_x       = SIGFIG'(e.v2x);
        v2_y       = SIGFIG'(e.v2y);
        samp_x[0]  = SIGFIG'(e.s0x);
        samp_y[0]  = SIGFIG'(e.s0y);
        samp_x[1]  = SIGFIG'(e.s1x);
        samp_y[1]  = SIGFIG'(e.s1y);
        samp_valid = e.valid;
        exp_hit    = e.exp;
        entry_idx  = idx;                            // Negative means no table value
        test_name  = e.name;
    endtask

    function automatic int rand_coord();
        return int'($urandom % 2001) - 1000;         // Within +-1000
    endfunction

    initial begin
        entry_t e;
        int     base;
        int     wait_cnt;
        int     err_assert;
        bit     timed_out;
        e = '0;
        e.name = "idle";
        drive(e, -1);                                // All inputs known at time 0
        arst_n = 1'b0;
        load_table();
        void'($urandom(92));
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        repeat (2) @(posedge clk);                   // Empty pipe seen right after reset
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            #2 drive(table_e[i], i);                 // Back to back
        end
        for (int r = 0; r < NUM_RANDOM; r++) begin
            base  = (r % 3 == 0) ? -8000000 : 0;     // Every third one far negative
            e.v0x = base + rand_coord();
            e.v0y = base + rand_coord();
            e.v1x = base + rand_coord();
            e.v1y = base + rand_coord();
            e.v2x = base + rand_coord();
            e.v2y = base + rand_coord();
            e.s0x = (e.v0x + e.v1x + e.v2x) / 3;     // Centroid, hits when CCW
            e.s0y = (e.v0y + e.v1y + e.v2y) / 3;
            e.s1x = base + rand_coord();
            e.s1y = base + rand_coord();
            e.valid = 2'($urandom % 4);
            e.exp   = 2'b00;
            e.name  = "random";
            @(posedge clk);
            #2 drive(e, -1);
        end
        e = '0;
        e.name = "idle";
        @(posedge clk);
        #2 drive(e, -1);
        wait_cnt = 0;
        while (busy && wait_cnt < DRAIN_MAX) begin
            @(negedge clk);
            wait_cnt++;
        end
        timed_out = busy;
        if (timed_out) begin
            $display("Timeout: results still pending after %0d cycles", DRAIN_MAX);
        end
        err_assert = i_rast_sample_top.i_sample_test.i_sample_test_assert.n_fail;
        $display("Errors: hit_valid %0d, hit %0d, table %0d, assertions %0d",
                 err_valid, err_hit, err_table, err_assert);
        if (!timed_out && err_valid + err_hit + err_table + err_assert == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/sample_test_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Valid timing and reset properties of sample_test
module sample_test_assert import rast_pkg::*; #(
    parameter int NUM_SAMPLES = 2
) (
    input logic                   clk,
    input logic                   arst_n,
    input logic [NUM_SAMPLES-1:0] samp_valid,
    input logic [NUM_SAMPLES-1:0] hit,
    input logic [NUM_SAMPLES-1:0] hit_valid
);

    int n_fail = 0;                               // Failed properties so far

    // No hit for a sample that entered without its valid bit
    a_hit_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (hit & ~$past(samp_valid, SAMPLE_LAT)) == '0)
        else begin
            n_fail++;
            $error("hit set on a sample that entered without samp_valid");
        end

    // Fixed latency, no stalls
    a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        hit_valid == $past(samp_valid, SAMPLE_LAT))
        else begin
            n_fail++;
            $error("hit_valid does not follow samp_valid by the pipeline latency");
        end

    a_reset_clear: assert property (@(posedge clk) !arst_n |-> hit_valid == '0)
        else begin
            n_fail++;
            $error("hit_valid set while in reset");
        end

endmodule

bind sample_test sample_test_assert #(
    .NUM_SAMPLES (NUM_SAMPLES)
) i_sample_test_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .samp_valid (samp_valid),
    .hit        (hit),
    .hit_valid  (hit_valid)
);

`default_nettype wire

//--- sim/sample_sb.sv
`timescale 1ns/1ps
`default_nettype none

// Scoreboard, recomputes every hit from the delayed DUT inputs
module sample_sb import rast_pkg::*; #(
    parameter int SIGFIG      = 24,
    parameter int NUM_SAMPLES = 2
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [SIGFIG-1:0]      v0_x,
    input  logic signed [SIGFIG-1:0]      v0_y,
    input  logic signed [SIGFIG-1:0]      v1_x,
    input  logic signed [SIGFIG-1:0]      v1_y,
    input  logic signed [SIGFIG-1:0]      v2_x,
    input  logic signed [SIGFIG-1:0]      v2_y,
    input  logic signed [SIGFIG-1:0]      samp_x [NUM_SAMPLES],
    input  logic signed [SIGFIG-1:0]      samp_y [NUM_SAMPLES],
    input  logic        [NUM_SAMPLES-1:0] samp_valid,
    input  logic        [NUM_SAMPLES-1:0] hit,
    input  logic        [NUM_SAMPLES-1:0] hit_valid,
    input  logic        [NUM_SAMPLES-1:0] exp_hit,      // From the table, else unused
    input  int                            entry_idx,    // Negative outside the table
    input  logic        [127:0]           test_name,
    output int                            err_valid,
    output int                            err_hit,
    output int                            err_table,
    output logic                          busy          // Valid samples still in flight
);

    localparam int  L     = SAMPLE_LAT - 1;             // Stage that lines up with outputs
    localparam real SCALE = real'(1 << DEF_RADIX);      // Fixed point to real

    logic signed [SIGFIG-1:0] vtx_q [SAMPLE_LAT][6];    // v0x v0y v1x v1y v2x v2y
    logic signed [SIGFIG-1:0] sx_q  [SAMPLE_LAT][NUM_SAMPLES];
    logic signed [SIGFIG-1:0] sy_q  [SAMPLE_LAT][NUM_SAMPLES];
    logic [NUM_SAMPLES-1:0]   vld_q [SAMPLE_LAT];
    logic [NUM_SAMPLES-1:0]   exp_q [SAMPLE_LAT];
    int                       idx_q [SAMPLE_LAT];
    logic [127:0]             name_q [SAMPLE_LAT];

    int n_valid = 0;
    int n_hit   = 0;
    int n_table = 0;

    // Edge rule at full precision, strictly left of all three CCW edges
    function automatic bit inside_ccw(input longint ax, input longint ay,
                                      input longint bx, input longint by,
                                      input longint cx, input longint cy,
                                      input longint px, input longint py);
        longint e0;
        longint e1;
        longint e2;
        e0 = (bx - ax) * (py - ay) - (by - ay) * (px - ax);  // Edge v0 to v1
        e1 = (cx - bx) * (py - by) - (cy - by) * (px - bx);  // Edge v1 to v2
        e2 = (ax - cx) * (py - cy) - (ay - cy) * (px - cx);  // Edge v2 to v0
        return (e0 > 0) && (e1 > 0) && (e2 > 0);
    endfunction

    // Valid bits cleared by reset like the DUT
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < SAMPLE_LAT; k++) begin
                vld_q[k] <= '0;
            end
        end else begin
            vld_q[0] <= samp_valid;
            for (int k = 1; k < SAMPLE_LAT; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
        end
    end

    // Data and table info, shifted alongside
    always @(posedge clk) begin
        vtx_q[0]  <= '{v0_x, v0_y, v1_x, v1_y, v2_x, v2_y};
        sx_q[0]   <= samp_x;
        sy_q[0]   <= samp_y;
        exp_q[0]  <= exp_hit;
        idx_q[0]  <= entry_idx;
        name_q[0] <= test_name;
        for (int k = 1; k < SAMPLE_LAT; k++) begin
            vtx_q[k]  <= vtx_q[k-1];
            sx_q[k]   <= sx_q[k-1];
            sy_q[k]   <= sy_q[k-1];
            exp_q[k]  <= exp_q[k-1];
            idx_q[k]  <= idx_q[k-1];
            name_q[k] <= name_q[k-1];
        end
    end

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        bit   rule;
        logic want;
        if (arst_n) begin
            for (int s = 0; s < NUM_SAMPLES; s++) begin
                rule = inside_ccw(vtx_q[L][0], vtx_q[L][1], vtx_q[L][2], vtx_q[L][3],
                                  vtx_q[L][4], vtx_q[L][5], sx_q[L][s], sy_q[L][s]);
                want = vld_q[L][s] & rule;                       // Masked like the DUT
                if (hit_valid[s] !== vld_q[L][s]) begin
                    n_valid++;
                    $display("Error %0s sample %0d hit_valid: expected %0b actual %0b",
                             name_q[L], s, vld_q[L][s], hit_valid[s]);
                end
                if (hit[s] !== want) begin
                    n_hit++;
                    $display("Error %0s sample %0d (%f, %f) hit: expected %0b actual %0b",
                             name_q[L], s, $itor(sx_q[L][s]) / SCALE,
                             $itor(sy_q[L][s]) / SCALE, want, hit[s]);
                end
                if (idx_q[L] >= 0 && want !== exp_q[L][s]) begin  // Table entries only
                    n_table++;
                    $display("Error %0s sample %0d table: expected %0b actual %0b",
                             name_q[L], s, exp_q[L][s], want);
                end
            end
        end
    end

    always_comb begin
        busy = 1'b0;
        for (int k = 0; k < SAMPLE_LAT; k++) begin
            busy = busy | (|vld_q[k]);
        end
    end

    assign err_valid = n_valid;
    assign err_hit   = n_hit;
    assign err_table = n_table;

endmodule

`default_nettype wire

//--- verilog/rast_sample_top.sv
`timescale 1ns/1ps
`default_nettype none

// Top of the sample test, fixes the pipeline geometry
module rast_sample_top import rast_pkg::*; #(
    parameter int SIGFIG      = DEF_SIGFIG,           // Coordinate width
    parameter int NUM_SAMPLES = DEF_NUM_SAMPLES       // Samples per cycle
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [SIGFIG-1:0]      v0_x,
    input  logic signed [SIGFIG-1:0]      v0_y,
    input  logic signed [SIGFIG-1:0]      v1_x,
    input  logic signed [SIGFIG-1:0]      v1_y,
    input  logic signed [SIGFIG-1:0]      v2_x,
    input  logic signed [SIGFIG-1:0]      v2_y,
    input  logic signed [SIGFIG-1:0]      samp_x [NUM_SAMPLES],
    input  logic signed [SIGFIG-1:0]      samp_y [NUM_SAMPLES],
    input  logic        [NUM_SAMPLES-1:0] samp_valid,
    output logic        [NUM_SAMPLES-1:0] hit,        // Three cycles after input
    output logic        [NUM_SAMPLES-1:0] hit_valid
);

    sample_test #(
        .SIGFIG      (SIGFIG),
        .NUM_SAMPLES (NUM_SAMPLES)
    ) i_sample_test (
        .clk        (clk),
        .arst_n     (arst_n),
        .v0_x       (v0_x),
        .v0_y       (v0_y),
        .v1_x       (v1_x),
        .v1_y       (v1_y),
        .v2_x       (v2_x),
        .v2_y       (v2_y),
        .samp_x     (samp_x),
        .samp_y     (samp_y),
        .samp_valid (samp_valid),
        .hit        (hit),
        .hit_valid  (hit_valid)
    );

endmodule

`default_nettype wire

//--- sample_test/sample_test.sv
`timescale 1ns/1ps
`default_nettype none

// Point in triangle test for NUM_SAMPLES samples per cycle
module sample_test import rast_pkg::*; #(
    parameter int SIGFIG      = 24,                   // Coordinate width
    parameter int NUM_SAMPLES = 2                     // Samples per triangle
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [SIGFIG-1:0]      v0_x,
    input  logic signed [SIGFIG-1:0]      v0_y,
    input  logic signed [SIGFIG-1:0]      v1_x,
    input  logic signed [SIGFIG-1:0]      v1_y,
    input  logic signed [SIGFIG-1:0]      v2_x,
    input  logic signed [SIGFIG-1:0]      v2_y,
    input  logic signed [SIGFIG-1:0]      samp_x [NUM_SAMPLES],
    input  logic signed [SIGFIG-1:0]      samp_y [NUM_SAMPLES],
    input  logic        [NUM_SAMPLES-1:0] samp_valid,
    output logic        [NUM_SAMPLES-1:0] hit,
    output logic        [NUM_SAMPLES-1:0] hit_valid
);

    // Stage 1 edge vectors, one set for all samples
    logic signed [SIGFIG:0] e01_x_q;
    logic signed [SIGFIG:0] e01_y_q;
    logic signed [SIGFIG:0] e12_x_q;
    logic signed [SIGFIG:0] e12_y_q;
    logic signed [SIGFIG:0] e20_x_q;
    logic signed [SIGFIG:0] e20_y_q;

    logic [NUM_SAMPLES-1:0] hit_raw;                  // Stage 3, not yet masked

    always_ff @(posedge clk) begin
        e01_x_q <= v1_x - v0_x;                       // One extra bit, no overflow
        e01_y_q <= v1_y - v0_y;
        e12_x_q <= v2_x - v1_x;
        e12_y_q <= v2_y - v1_y;
        e20_x_q <= v0_x - v2_x;
        e20_y_q <= v0_y - v2_y;
    end

    for (genvar s = 0; s < NUM_SAMPLES; s++) begin : g_samp
        logic signed [SIGFIG:0] d0_x_q;               // Sample relative to v0
        logic signed [SIGFIG:0] d0_y_q;
        logic signed [SIGFIG:0] d1_x_q;               // Sample relative to v1
        logic signed [SIGFIG:0] d1_y_q;
        logic signed [SIGFIG:0] d2_x_q;               // Sample relative to v2
        logic signed [SIGFIG:0] d2_y_q;

        always_ff @(posedge clk) begin
            d0_x_q <= samp_x[s] - v0_x;
            d0_y_q <= samp_y[s] - v0_y;
            d1_x_q <= samp_x[s] - v1_x;
            d1_y_q <= samp_y[s] - v1_y;
            d2_x_q <= samp_x[s] - v2_x;
            d2_y_q <= samp_y[s] - v2_y;
        end

        sample_edge #(
            .SIGFIG (SIGFIG)
        ) i_sample_edge (
            .clk   (clk),
            .e01_x (e01_x_q),
            .e01_y (e01_y_q),
            .e12_x (e12_x_q),
            .e12_y (e12_y_q),
            .e20_x (e20_x_q),
            .e20_y (e20_y_q),
            .d0_x  (d0_x_q),
            .d0_y  (d0_y_q),
            .d1_x  (d1_x_q),
            .d1_y  (d1_y_q),
            .d2_x  (d2_x_q),
            .d2_y  (d2_y_q),
            .hit   (hit_raw[s])
        );
    end

    // Valid bits follow the data through all three stages
    pipe_dly #(
        .DEPTH (SAMPLE_LAT),
        .WIDTH (NUM_SAMPLES)
    ) i_valid_dly (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (samp_valid),
        .q      (hit_valid)
    );

    assign hit = hit_raw & hit_valid;                 // Invalid samples never hit

endmodule

`default_nettype wire

//--- sample_test/sample_edge.sv
`timescale 1ns/1ps
`default_nettype none

// Stages 2 and 3 of one sample against the three triangle edges
module sample_edge import rast_pkg::*; #(
    parameter int SIGFIG = 24                       // Coordinate width
) (
    input  logic                     clk,
    // Edge vectors vb - va, from stage 1
    input  logic signed [SIGFIG:0]   e01_x,
    input  logic signed [SIGFIG:0]   e01_y,
    input  logic signed [SIGFIG:0]   e12_x,
    input  logic signed [SIGFIG:0]   e12_y,
    input  logic signed [SIGFIG:0]   e20_x,
    input  logic signed [SIGFIG:0]   e20_y,
    // Sample minus start vertex of each edge, from stage 1
    input  logic signed [SIGFIG:0]   d0_x,
    input  logic signed [SIGFIG:0]   d0_y,
    input  logic signed [SIGFIG:0]   d1_x,
    input  logic signed [SIGFIG:0]   d1_y,
    input  logic signed [SIGFIG:0]   d2_x,
    input  logic signed [SIGFIG:0]   d2_y,
    output logic                     hit            // Strictly inside, unmasked
);

    localparam int PW = 2 * SIGFIG + PROD_GROWTH;   // Full product width
    localparam int EW = 2 * SIGFIG + EDGE_GROWTH;   // Full edge value width

    // Stage 2 products
    logic signed [PW-1:0] p01_a_q;                  // e01.x * d0.y
    logic signed [PW-1:0] p01_b_q;                  // e01.y * d0.x
    logic signed [PW-1:0] p12_a_q;                  // e12.x * d1.y
    logic signed [PW-1:0] p12_b_q;                  // e12.y * d1.x
    logic signed [PW-1:0] p20_a_q;                  // e20.x * d2.y
    logic signed [PW-1:0] p20_b_q;                  // e20.y * d2.x

    // Edge values, combinational between stages 2 and 3
    logic signed [EW-1:0] ev01;
    logic signed [EW-1:0] ev12;
    logic signed [EW-1:0] ev20;

    logic                 pos01;                    // Edge v0->v1 strictly left
    logic                 pos12;                    // Edge v1->v2 strictly left
    logic                 pos20;                    // Edge v2->v0 strictly left

    // Stage 2, cross product halves
    always_ff @(posedge clk) begin
        p01_a_q <= e01_x * d0_y;
        p01_b_q <= e01_y * d0_x;
        p12_a_q <= e12_x * d1_y;
        p12_b_q <= e12_y * d1_x;
        p20_a_q <= e20_x * d2_y;
        p20_b_q <= e20_y * d2_x;
    end

    // Full precision differences, sign extended to EW
    assign ev01 = p01_a_q - p01_b_q;
    assign ev12 = p12_a_q - p12_b_q;
    assign ev20 = p20_a_q - p20_b_q;

    // Zero means on the edge, which is a miss
    assign pos01 = !ev01[EW-1] && (ev01 != '0);
    assign pos12 = !ev12[EW-1] && (ev12 != '0);
    assign pos20 = !ev20[EW-1] && (ev20 != '0);

    // Stage 3, all three edges positive for a CCW interior point
    // A clockwise triangle flips every sign and never hits
    always_ff @(posedge clk) begin
        hit <= pos01 && pos12 && pos20;
    end

endmodule

`default_nettype wire

//--- verilog/pipe_dly.sv
`timescale 1ns/1ps
`default_nettype none

// Plain delay line for control bits, no enable
module pipe_dly #(
    parameter int DEPTH = 3,               // Number of register stages
    parameter int WIDTH = 1                // Bits carried per stage
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] d,            // Enters stage 0
    output logic [WIDTH-1:0] q             // Leaves after DEPTH cycles
);

    logic [WIDTH-1:0] stage_q [DEPTH];     // Register chain

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;          // Nothing valid after reset
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1]; // Shift one stage
            end
        end
    end

    assign q = stage_q[DEPTH-1];           // Oldest entry

endmodule

`default_nettype wire

//--- common/rast_pkg.sv
`default_nettype none

// Shared constants of the sample test pipeline

package rast_pkg;

    // Pipeline timing
    localparam int SAMPLE_LAT = 3;       // Input edge to result, in cycles

    // Default geometry of one coordinate
    localparam int DEF_SIGFIG = 24;      // Signed coordinate width
    localparam int DEF_RADIX  = 10;      // Fraction bits, for printing only

    // Default parallelism
    localparam int DEF_NUM_SAMPLES = 2;  // Samples tested per cycle

    // Edge value growth over 2*SIGFIG
    // Differences add one bit to each operand and the product adds two.
    // The final subtraction of two products adds one more.
    localparam int EDGE_GROWTH = 3;      // Edge value is 2*SIGFIG+3 bits

    // Product width helper, relative to SIGFIG
    localparam int PROD_GROWTH = EDGE_GROWTH - 1; // One product, 2*SIGFIG+2

endpackage

`default_nettype wire
